// ==== vlog.f ====
+incdir+verilog
verilog/ahbPkg.sv
verilog/apbPkg.sv
verilog/ahbFabric.sv
verilog/ramAhb.sv
verilog/ahbApbBridge.sv
verilog/gpioApb.sv
verilog/clintApb.sv
verilog/uncore.sv
sim/uncore_assert.sv
sim/uncoreChecker.sv
sim/uncore_tb.sv

// ==== sim/uncore_tb.sv ====
// Uncore testbench
// Random AHB transfers to RAM, GPIO, timer and unmapped space,
// checked by uncoreChecker and the bound protocol assertions
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module uncore_tb;

  // 600 transfers at up to 3 cycles each, plus margin
  localparam int timeoutCycles = 600 * 3 + 1200;

  logic             HCLK, rstN, HREADY, HRESP, mTimerInt, mSwInt;
  logic [31:0]      gpioIn, gpioOut, gpioEn;
  logic [`XLEN-1:0] HRDATA;
  ahbPkg::ahbReqT   ahbReq;
  integer           seed = 32'h82334f2b;
  int               cycleCount = 0;
  int               errorCount, checkCount, assertFails;

  uncore dut_i (.HCLK, .rstN, .ahbReq, .gpioIn, .HRDATA, .HREADY, .HRESP,
    .gpioOut, .gpioEn, .mTimerInt, .mSwInt);

  uncoreChecker monitor (.HCLK, .rstN, .ahbReq, .gpioIn, .HRDATA, .HREADY, .HRESP,
    .gpioOut, .gpioEn, .mTimerInt, .mSwInt, .errorCount, .checkCount);

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  always @(posedge HCLK) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: run still busy after %0d cycles", timeoutCycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////////////////////////

  // Entered 1 ns after a rising edge with the bus idle
  task automatic runTransfer(input logic [31:0] addr, input logic write,
                             input logic [31:0] data, input logic [3:0] strb);
    ahbReq.haddr  = addr;
    ahbReq.hwrite = write;
    ahbReq.hsize  = 3'b010;
    ahbReq.htrans = 2'b10;
    @(posedge HCLK);
    #1;
    // Data phase, bus goes idle behind it
    ahbReq.htrans = 2'b00;
    ahbReq.hwdata = data;
    ahbReq.hwstrb = write ? strb : 4'h0;
    do @(negedge HCLK); while (!HREADY);
    @(posedge HCLK);
    #1;
  endtask

  task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    runTransfer(addr, 1'b1, data, strb);
  endtask

  task automatic busRead(input logic [31:0] addr);
    runTransfer(addr, 1'b0, 32'd0, 4'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////

  task automatic exerciseRam();
    logic [9:0]  idx;
    logic [31:0] addr;
    repeat (300) begin
      // Small pools at both ends so reads hit written words
      idx = {$random(seed)} % 64;
      if ($random(seed) & 1) idx = idx + (`RAM_WORDS - 64);
      addr = `RAM_BASE + {idx, 2'b00};
      if ($random(seed) & 1) busWrite(addr, $random(seed), 4'($random(seed)));
      else busRead(addr);
    end
  endtask

  task automatic exerciseGpio();
    int op;
    repeat (100) begin
      op = {$random(seed)} % 4;
      case (op)
        0: busWrite(`GPIO_BASE + `GPIO_OUT, $random(seed), 4'($random(seed)));
        1: busWrite(`GPIO_BASE + `GPIO_EN, $random(seed), 4'($random(seed)));
        2: busRead(`GPIO_BASE + (($random(seed) & 1) ? `GPIO_EN : `GPIO_OUT));
        default: begin
          // New pin value, left to settle before the read
          gpioIn = $random(seed);
          repeat (3) @(posedge HCLK);
          #1;
          busRead(`GPIO_BASE + `GPIO_IN);
        end
      endcase
    end
  endtask

  task automatic exerciseTimer();
    busWrite(`CLINT_BASE + `CLINT_MSIP, 32'd1, 4'hf);
    busRead(`CLINT_BASE + `CLINT_MSIP);
    busWrite(`CLINT_BASE + `CLINT_MSIP, 32'd0, 4'hf);
    repeat (4) begin
      busWrite(`CLINT_BASE + `CLINT_MSIP, $random(seed), 4'hf);
      busRead(`CLINT_BASE + `CLINT_MSIP);
    end
    // Compare at zero fires at once
    busWrite(`CLINT_BASE + `CLINT_CMP_HI, 32'd0, 4'hf);
    busWrite(`CLINT_BASE + `CLINT_CMP_LO, 32'd0, 4'hf);
    repeat (4) @(posedge HCLK);
    #1;
    busRead(`CLINT_BASE + `CLINT_CMP_LO);
    busWrite(`CLINT_BASE + `CLINT_CMP_HI, 32'hffff_ffff, 4'hf);
    busWrite(`CLINT_BASE + `CLINT_CMP_LO, 32'hffff_ffff, 4'hf);
    busRead(`CLINT_BASE + `CLINT_CMP_HI);
    busRead(`CLINT_BASE + `CLINT_TIME_LO);
    repeat (5) @(posedge HCLK);
    #1;
    busRead(`CLINT_BASE + `CLINT_TIME_LO);
    busRead(`CLINT_BASE + `CLINT_TIME_HI);
  endtask

  task automatic exerciseUnmapped();
    logic [31:0] addr;
    repeat (40) begin
      addr = $random(seed);
      // Top nibble 4 lies outside every region
      addr[31:28] = 4'h4;
      addr[1:0] = 2'b00;
      if ($random(seed) & 1) busWrite(addr, $random(seed), 4'hf);
      else busRead(addr);
    end
    // Just outside each region
    busRead(`RAM_BASE - 4);
    busWrite(`RAM_BASE + `RAM_WORDS * 4, $random(seed), 4'hf);
    busWrite(`GPIO_BASE + `PERIPH_SIZE, $random(seed), 4'hf);
    busRead(`CLINT_BASE - 4);
    // Registers must be untouched
    busRead(`GPIO_BASE + `GPIO_OUT);
    busRead(`GPIO_BASE + `GPIO_EN);
    busRead(`CLINT_BASE + `CLINT_MSIP);
  endtask

  initial begin
    ahbReq = '0;
    gpioIn = '0;
    rstN   = 1'b0;
    repeat (3) @(posedge HCLK);
    #1;
    rstN = 1'b1;
    // Idle cycles for the post reset state
    repeat (2) @(posedge HCLK);
    #1;
    exerciseRam();
    exerciseGpio();
    exerciseTimer();
    exerciseUnmapped();
    repeat (3) @(posedge HCLK);
    assertFails = dut_i.fabric.ahbRules.failCount + dut_i.bridge.apbRules.failCount;
    $display("Checks %0d, check errors %0d, assertion failures %0d",
             checkCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/uncoreChecker.sv ====
// Uncore checker
// Follows each AHB transfer on the DUT ports, keeps a model of RAM,
// GPIO and timer registers and compares reads and pins against it
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module uncoreChecker (
  input  logic             HCLK,
  input  logic             rstN,
  input  ahbPkg::ahbReqT   ahbReq,
  input  logic [31:0]      gpioIn,
  input  logic [`XLEN-1:0] HRDATA,
  input  logic             HREADY,
  input  logic             HRESP,
  input  logic [31:0]      gpioOut,
  input  logic [31:0]      gpioEn,
  input  logic             mTimerInt,
  input  logic             mSwInt,
  output int               errorCount,
  output int               checkCount
);

  // RAM words and a bit mask of the bytes written so far
  logic [`XLEN-1:0] ramData [`RAM_WORDS];
  logic [`XLEN-1:0] ramKnown [`RAM_WORDS];
  logic [31:0]      outModel, enModel, inHeld, lastTimeLo, pAddr;
  logic [63:0]      cmpModel;
  logic             msipModel, pending, pWrite, haveTime;
  int               inAge;

  initial begin
    errorCount = 0;
    checkCount = 0;
    for (int i = 0; i < `RAM_WORDS; i++) begin
      ramKnown[i] = '0;
    end
  end

  function automatic logic [31:0] mergeBytes(input logic [31:0] oldVal, input logic [31:0] newVal,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = oldVal;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = newVal[8*b +: 8];
    end
    return res;
  endfunction

  // Peripheral windows are 64 KB from their base
  function automatic logic inWindow(input logic [31:0] addr, input logic [31:0] base);
    return (addr >= base) && (addr < base + `PERIPH_SIZE);
  endfunction

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED time %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // End of a data phase
  ////////////////////////////////////////////////////////////

  task automatic completeTransfer();
    logic [15:0] offset;
    int          idx;
    logic [31:0] strbMask;
    offset   = pAddr[15:0];
    strbMask = mergeBytes('0, '1, ahbReq.hwstrb);
    compareValue("HRESP", 32'd0, {31'b0, HRESP});
    if (pAddr >= `RAM_BASE && pAddr < `RAM_BASE + `RAM_WORDS * 4) begin
      idx = (pAddr - `RAM_BASE) >> 2;
      if (pWrite) begin
        ramData[idx]  = mergeBytes(ramData[idx], ahbReq.hwdata, ahbReq.hwstrb);
        ramKnown[idx] = ramKnown[idx] | strbMask;
      end else begin
        // Bytes never written are left out
        compareValue($sformatf("HRDATA (RAM %h)", pAddr), ramData[idx] & ramKnown[idx],
                     HRDATA & ramKnown[idx]);
      end
    end else if (inWindow(pAddr, `GPIO_BASE)) begin
      if (pWrite) begin
        if (offset == `GPIO_OUT) outModel = mergeBytes(outModel, ahbReq.hwdata, ahbReq.hwstrb);
        if (offset == `GPIO_EN) enModel = mergeBytes(enModel, ahbReq.hwdata, ahbReq.hwstrb);
      end else begin
        case (offset)
          `GPIO_OUT: compareValue("HRDATA (gpio out)", outModel, HRDATA);
          `GPIO_EN:  compareValue("HRDATA (gpio en)", enModel, HRDATA);
          // Pins must have settled through the synchronizer
          `GPIO_IN:  if (inAge >= 3) compareValue("HRDATA (gpio in)", inHeld, HRDATA);
          default:   compareValue("HRDATA (gpio hole)", 32'd0, HRDATA);
        endcase
      end
    end else if (inWindow(pAddr, `CLINT_BASE)) begin
      if (pWrite) begin
        if (offset == `CLINT_MSIP && ahbReq.hwstrb[0]) msipModel = ahbReq.hwdata[0];
        if (offset == `CLINT_CMP_LO) begin
          cmpModel[31:0] = mergeBytes(cmpModel[31:0], ahbReq.hwdata, ahbReq.hwstrb);
        end
        if (offset == `CLINT_CMP_HI) begin
          cmpModel[63:32] = mergeBytes(cmpModel[63:32], ahbReq.hwdata, ahbReq.hwstrb);
        end
      end else begin
        case (offset)
          `CLINT_MSIP:    compareValue("HRDATA (msip)", {31'b0, msipModel}, HRDATA);
          `CLINT_CMP_LO:  compareValue("HRDATA (mtimecmp lo)", cmpModel[31:0], HRDATA);
          `CLINT_CMP_HI:  compareValue("HRDATA (mtimecmp hi)", cmpModel[63:32], HRDATA);
          // Run is far too short for the low half to carry
          `CLINT_TIME_HI: compareValue("HRDATA (mtime hi)", 32'd0, HRDATA);
          `CLINT_TIME_LO: begin
            checkCount++;
            if ($isunknown(HRDATA) || (haveTime && HRDATA <= lastTimeLo)) begin
              errorCount++;
              $display("CHECK FAILED time %0t: HRDATA (mtime lo) expected above %h, actual %h",
                       $time, lastTimeLo, HRDATA);
            end
            lastTimeLo = HRDATA;
            haveTime   = 1'b1;
          end
          default: compareValue("HRDATA (timer hole)", 32'd0, HRDATA);
        endcase
      end
    end else if (!pWrite) begin
      compareValue("HRDATA (unmapped)", 32'd0, HRDATA);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling at the falling edge, mid cycle
  ////////////////////////////////////////////////////////////

  always @(negedge HCLK) begin
    if (!rstN) begin
      outModel  = '0;
      enModel   = '0;
      msipModel = 1'b0;
      cmpModel  = '1;
      pending   = 1'b0;
      haveTime  = 1'b0;
      inHeld    = gpioIn;
      inAge     = 0;
    end else begin
      // Pins follow the model
      compareValue("gpioOut", outModel, gpioOut);
      compareValue("gpioEn", enModel, gpioEn);
      compareValue("mSwInt", {31'b0, msipModel}, {31'b0, mSwInt});
      // Interrupt level is only certain at the two extremes of mtimecmp
      if (cmpModel == '0) compareValue("mTimerInt", 32'd1, {31'b0, mTimerInt});
      else if (cmpModel == '1) compareValue("mTimerInt", 32'd0, {31'b0, mTimerInt});
      if (!pending) compareValue("HREADY", 32'd1, {31'b0, HREADY});
      // How long the pins have been stable
      if (gpioIn === inHeld) begin
        inAge++;
      end else begin
        inHeld = gpioIn;
        inAge  = 0;
      end
      if (pending && HREADY) begin
        completeTransfer();
        pending = 1'b0;
      end
      // New address phase
      if (HREADY && ahbReq.htrans[1]) begin
        pending = 1'b1;
        pAddr   = ahbReq.haddr;
        pWrite  = ahbReq.hwrite;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/uncore_assert.sv ====
// Protocol assertions
// AHB response and APB phase rules, bound into the fabric and the bridge
`timescale 1ns/1ps
`default_nettype none

module uncore_assert #(
  parameter bit apbSide = 1'b0
) (
  input logic HCLK,
  input logic rstN,
  input logic HREADY,
  input logic HRESP,
  input logic psel,
  input logic penable
);

  int failCount = 0;

  if (!apbSide) begin : ahbChecks
    // No slave in this uncore signals an error
    noErrorResp: assert property (@(posedge HCLK) disable iff (!rstN) !HRESP)
      else begin
        failCount++;
        $error("HRESP raised during a transfer");
      end

    // Longest data phase is 2 cycles, so one wait cycle at most
    shortDataPhase: assert property (@(posedge HCLK) disable iff (!rstN) !HREADY |=> HREADY)
      else begin
        failCount++;
        $error("Data phase longer than 2 cycles");
      end
  end else begin : apbChecks
    // Access phase only after a setup cycle
    enableAfterSetup: assert property (@(posedge HCLK) disable iff (!rstN)
      $rose(penable) |-> $past(psel && !penable))
      else begin
        failCount++;
        $error("penable rose without a setup cycle");
      end
  end

endmodule

// Fabric copy watches the merged AHB reply
bind ahbFabric uncore_assert ahbRules (.HCLK, .rstN, .HREADY, .HRESP,
  .psel(1'b0), .penable(1'b0));

// Bridge copy watches the APB phases
bind ahbApbBridge uncore_assert #(.apbSide(1'b1)) apbRules (.HCLK, .rstN, .HREADY,
  .HRESP(resp.hresp), .psel(|apbReq.psel), .penable(apbReq.penable));

`default_nettype wire

// ==== verilog/uncore.sv ====
// Uncore top
// AHB-Lite fabric with on-chip RAM, and GPIO and timer behind an APB bridge
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module uncore (
  input  logic                HCLK,
  input  logic                rstN,
  input  ahbPkg::ahbReqT      ahbReq,
  input  logic [31:0]         gpioIn,
  output logic [`XLEN-1:0]    HRDATA,
  output logic                HREADY,
  output logic                HRESP,
  output logic [31:0]         gpioOut,
  output logic [31:0]         gpioEn,
  output logic                mTimerInt,
  output logic                mSwInt
);

  // Address-phase selects
  logic hselRam, hselBridge, hselGpio, hselClint;
  // Slave replies
  ahbPkg::ahbRespT ramResp, bridgeResp;
  // APB side
  apbPkg::apbReqT  apbReq;
  apbPkg::apbRespT gpioResp, clintResp;

  // HREADY from the fabric is the previous-transfer-done qualifier for all slaves
  ahbFabric fabric (.HCLK, .rstN, .ahbReq, .ramResp, .bridgeResp,
    .hselRam, .hselBridge, .hselGpio, .hselClint, .HRDATA, .HREADY, .HRESP);

  ramAhb ram (.HCLK, .rstN, .hsel(hselRam), .ahbReq, .HREADY, .resp(ramResp));

  ahbApbBridge bridge (.HCLK, .rstN, .hsel(hselBridge), .hselPeriph({hselClint, hselGpio}),
    .ahbReq, .HREADY, .gpioResp, .clintResp, .apbReq, .resp(bridgeResp));

  gpioApb gpio (.HCLK, .rstN, .apbReq, .gpioIn, .apbResp(gpioResp), .gpioOut, .gpioEn);

  clintApb clint (.HCLK, .rstN, .apbReq, .apbResp(clintResp), .mTimerInt, .mSwInt);

endmodule

`default_nettype wire

// ==== verilog/clintApb.sv ====
// Core-local timer on APB
// Free running 64-bit mtime, mtimecmp compare and software interrupt bit
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module clintApb (
  input  logic            HCLK,
  input  logic            rstN,
  input  apbPkg::apbReqT  apbReq,
  output apbPkg::apbRespT apbResp,
  output logic            mTimerInt,
  output logic            mSwInt
);

  logic [63:0]      mtime, mtimecmp;
  logic             msip, wrEn;
  logic [`XLEN-1:0] rdata, merged;

  assign wrEn = apbReq.psel[1] & apbReq.penable & apbReq.pwrite;

  always_comb begin
    case (apbReq.paddr)
      `CLINT_MSIP:    rdata = {31'b0, msip};
      `CLINT_CMP_LO:  rdata = mtimecmp[31:0];
      `CLINT_CMP_HI:  rdata = mtimecmp[63:32];
      `CLINT_TIME_LO: rdata = mtime[31:0];
      `CLINT_TIME_HI: rdata = mtime[63:32];
      default:        rdata = '0;
    endcase
  end

  // Byte merge of write data onto the addressed register
  always_comb begin
    merged = rdata;
    for (int b = 0; b < `XLEN / 8; b++) begin
      if (apbReq.pstrb[b]) merged[8*b +: 8] = apbReq.pwdata[8*b +: 8];
    end
  end

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      msip     <= 1'b0;
      mtimecmp <= '1;
      mtime    <= '0;
    end else begin
      if (wrEn && apbReq.paddr == `CLINT_MSIP) msip <= merged[0];
      if (wrEn && apbReq.paddr == `CLINT_CMP_LO) mtimecmp[31:0] <= merged;
      if (wrEn && apbReq.paddr == `CLINT_CMP_HI) mtimecmp[63:32] <= merged;
      // A write to either half wins over the tick
      if (wrEn && apbReq.paddr == `CLINT_TIME_LO) mtime <= {mtime[63:32], merged};
      else if (wrEn && apbReq.paddr == `CLINT_TIME_HI) mtime <= {merged, mtime[31:0]};
      else mtime <= mtime + 64'd1;
    end
  end

  // Interrupts
  assign mTimerInt = mtime >= mtimecmp;
  assign mSwInt    = msip;

  assign apbResp.prdata = rdata;
  assign apbResp.pready = 1'b1;

endmodule

`default_nettype wire

// ==== verilog/gpioApb.sv ====
// GPIO on APB
// Output and enable registers, synchronized input pins
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module gpioApb (
  input  logic            HCLK,
  input  logic            rstN,
  input  apbPkg::apbReqT  apbReq,
  input  logic [31:0]     gpioIn,
  output apbPkg::apbRespT apbResp,
  output logic [31:0]     gpioOut,
  output logic [31:0]     gpioEn
);

  logic             wrEn;
  logic [31:0]      inMeta, inSync;
  logic [`XLEN-1:0] rdata, merged;

  assign wrEn = apbReq.psel[0] & apbReq.penable & apbReq.pwrite;

  // Register readback
  always_comb begin
    case (apbReq.paddr)
      `GPIO_OUT: rdata = gpioOut;
      `GPIO_EN:  rdata = gpioEn;
      `GPIO_IN:  rdata = inSync;
      default:   rdata = '0;
    endcase
  end

  // Strobed bytes replace the current value
  always_comb begin
    merged = rdata;
    for (int b = 0; b < `XLEN / 8; b++) begin
      if (apbReq.pstrb[b]) merged[8*b +: 8] = apbReq.pwdata[8*b +: 8];
    end
  end

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      gpioOut <= '0;
      gpioEn  <= '0;
      inMeta  <= '0;
      inSync  <= '0;
    end else begin
      // Two flop synchronizer on the pins
      inMeta <= gpioIn;
      inSync <= inMeta;
      if (wrEn && apbReq.paddr == `GPIO_OUT) gpioOut <= merged;
      if (wrEn && apbReq.paddr == `GPIO_EN) gpioEn <= merged;
    end
  end

  assign apbResp.prdata = rdata;
  assign apbResp.pready = 1'b1;

endmodule

`default_nettype wire

// ==== verilog/ahbApbBridge.sv ====
// AHB to APB bridge
// Turns one AHB transfer into an APB setup and access pair
// for the GPIO and timer peripherals
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module ahbApbBridge (
  input  logic            HCLK,
  input  logic            rstN,
  input  logic            hsel,
  input  logic [1:0]      hselPeriph,
  input  ahbPkg::ahbReqT  ahbReq,
  input  logic            HREADY,
  input  apbPkg::apbRespT gpioResp,
  input  apbPkg::apbRespT clintResp,
  output apbPkg::apbReqT  apbReq,
  output ahbPkg::ahbRespT resp
);

  typedef enum logic [1:0] {stIdle, stSetup, stAccess} stateT;

  stateT                  state, stateNext;
  logic                   accept, periphReady;
  logic [1:0]             pselQ;
  logic                   pwriteQ;
  logic [`PADDR_BITS-1:0] paddrQ;
  logic [`XLEN-1:0]       wdataQ;
  logic [`XLEN/8-1:0]     strbQ;

  // New transfer on this cycle's address phase
  assign accept = hsel & ahbReq.htrans[1] & HREADY;
  assign periphReady = (pselQ[0] & gpioResp.pready) | (pselQ[1] & clintResp.pready);

  always_comb begin
    case (state)
      stIdle:   stateNext = accept ? stSetup : stIdle;
      stSetup:  stateNext = stAccess;
      // Back to back transfers go straight into setup
      stAccess: stateNext = !periphReady ? stAccess : (accept ? stSetup : stIdle);
      default:  stateNext = stIdle;
    endcase
  end

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      state   <= stIdle;
      pselQ   <= 2'b00;
      pwriteQ <= 1'b0;
    end else begin
      state <= stateNext;
      if (accept) begin
        pselQ   <= hselPeriph;
        pwriteQ <= ahbReq.hwrite;
      end
    end
  end

  // Address on accept, write data once the data phase has begun
  always_ff @(posedge HCLK) begin
    if (accept) paddrQ <= ahbReq.haddr[`PADDR_BITS-1:0];
    if (state == stSetup) begin
      wdataQ <= ahbReq.hwdata;
      strbQ  <= ahbReq.hwstrb;
    end
  end

  ////////////////////////////////////////////////////////////
  // APB outputs
  ////////////////////////////////////////////////////////////

  assign apbReq.psel    = (state == stIdle) ? 2'b00 : pselQ;
  assign apbReq.penable = state == stAccess;
  assign apbReq.pwrite  = pwriteQ;
  assign apbReq.paddr   = paddrQ;
  // Setup uses the live bus, access the captured copy
  assign apbReq.pwdata  = (state == stSetup) ? ahbReq.hwdata : wdataQ;
  assign apbReq.pstrb   = !pwriteQ ? '0 : ((state == stSetup) ? ahbReq.hwstrb : strbQ);

  // AHB reply
  assign resp.hrdata    = ({`XLEN{pselQ[0]}} & gpioResp.prdata) |
                          ({`XLEN{pselQ[1]}} & clintResp.prdata);
  assign resp.hreadyout = (state == stIdle) | ((state == stAccess) & periphReady);
  assign resp.hresp     = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/ramAhb.sv ====
// On-chip RAM
// Zero wait state AHB slave with byte write strobes and asynchronous read
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module ramAhb (
  input  logic            HCLK,
  input  logic            rstN,
  input  logic            hsel,
  input  ahbPkg::ahbReqT  ahbReq,
  input  logic            HREADY,
  output ahbPkg::ahbRespT resp
);

  localparam int idxBits = $clog2(`RAM_WORDS);

  logic [`XLEN-1:0]   mem [`RAM_WORDS];
  logic [idxBits-1:0] idxQ;
  logic               activeQ, writeQ;

  // Address phase capture
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      activeQ <= 1'b0;
      writeQ  <= 1'b0;
    end else if (HREADY) begin
      activeQ <= hsel & ahbReq.htrans[1];
      writeQ  <= ahbReq.hwrite;
    end
  end

  // Word index, byte offset dropped
  always_ff @(posedge HCLK) begin
    if (HREADY) idxQ <= ahbReq.haddr[idxBits+1:2];
  end

  // Data phase write under strobes
  always_ff @(posedge HCLK) begin
    if (activeQ && writeQ) begin
      for (int b = 0; b < `XLEN / 8; b++) begin
        if (ahbReq.hwstrb[b]) mem[idxQ][8*b +: 8] <= ahbReq.hwdata[8*b +: 8];
      end
    end
  end

  // Always ready, never errors
  assign resp.hrdata    = mem[idxQ];
  assign resp.hreadyout = 1'b1;
  assign resp.hresp     = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/ahbFabric.sv ====
// AHB-Lite fabric
// Decodes the address phase into a region, holds it through the data phase
// and merges the slave replies back to the master
`timescale 1ns/1ps
`default_nettype none

`include "uncore_consts.svh"

module ahbFabric (
  input  logic               HCLK,
  input  logic               rstN,
  input  ahbPkg::ahbReqT     ahbReq,
  input  ahbPkg::ahbRespT    ramResp,
  input  ahbPkg::ahbRespT    bridgeResp,
  output logic               hselRam,
  output logic               hselBridge,
  output logic               hselGpio,
  output logic               hselClint,
  output logic [`XLEN-1:0]   HRDATA,
  output logic               HREADY,
  output logic               HRESP
);

  localparam logic [`PA_BITS-1:0] ramLimit = `RAM_BASE + `RAM_WORDS * 4;

  ahbPkg::regionT region, regionQ;
  logic selRamQ, selBridgeQ, selNoneQ;

  ////////////////////////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////////////////////////

  assign hselRam   = (ahbReq.haddr >= `RAM_BASE) && (ahbReq.haddr < ramLimit);
  // Peripheral windows are size aligned
  assign hselGpio  = (ahbReq.haddr & ~(`PERIPH_SIZE - 1)) == `GPIO_BASE;
  assign hselClint = (ahbReq.haddr & ~(`PERIPH_SIZE - 1)) == `CLINT_BASE;
  assign hselBridge = hselGpio | hselClint;

  always_comb begin
    if (hselRam) region = ahbPkg::regionRam;
    else if (hselGpio) region = ahbPkg::regionGpio;
    else if (hselClint) region = ahbPkg::regionClint;
    else region = ahbPkg::regionNone;
  end

  ////////////////////////////////////////////////////////////
  // Data phase select
  ////////////////////////////////////////////////////////////

  // Only moves when the previous transfer is done, so a slow slave keeps its select
  // IDLE and BUSY cycles leave no data phase behind
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      regionQ <= ahbPkg::regionNone;
    end else if (HREADY) begin
      regionQ <= ahbReq.htrans[1] ? region : ahbPkg::regionNone;
    end
  end

  assign selRamQ    = regionQ == ahbPkg::regionRam;
  assign selBridgeQ = (regionQ == ahbPkg::regionGpio) || (regionQ == ahbPkg::regionClint);
  assign selNoneQ   = regionQ == ahbPkg::regionNone;

  // Response merge
  assign HRDATA = ({`XLEN{selRamQ}} & ramResp.hrdata) |
                  ({`XLEN{selBridgeQ}} & bridgeResp.hrdata);

  // Unmapped space answers at once so the bus never hangs
  assign HREADY = (selRamQ & ramResp.hreadyout) |
                  (selBridgeQ & bridgeResp.hreadyout) |
                  selNoneQ;

  assign HRESP = (selRamQ & ramResp.hresp) | (selBridgeQ & bridgeResp.hresp);

endmodule

`default_nettype wire

// ==== verilog/apbPkg.sv ====
// APB-side types
// Bridge request shared by the peripherals and one peripheral reply
`default_nettype none

`include "uncore_consts.svh"

package apbPkg;

  // psel bit 0 is GPIO, bit 1 is the timer
  typedef struct packed {
    logic [1:0]             psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PADDR_BITS-1:0] paddr;
    logic [`XLEN-1:0]       pwdata;
    logic [`XLEN/8-1:0]     pstrb;
  } apbReqT;

  typedef struct packed {
    logic [`XLEN-1:0] prdata;
    logic             pready;
  } apbRespT;

endpackage

`default_nettype wire

// ==== verilog/ahbPkg.sv ====
// AHB-side types
// Master request, per-slave reply and the decoded region
`default_nettype none

`include "uncore_consts.svh"

package ahbPkg;

  // One transfer as driven by the master
  // hwdata and hwstrb belong to the data phase
  typedef struct packed {
    logic [`PA_BITS-1:0] haddr;
    logic [`XLEN-1:0]    hwdata;
    logic [`XLEN/8-1:0]  hwstrb;
    logic                hwrite;
    logic [2:0]          hsize;
    logic [1:0]          htrans;
  } ahbReqT;

  // Reply of one slave, merged by the fabric
  typedef struct packed {
    logic [`XLEN-1:0] hrdata;
    logic             hreadyout;
    logic             hresp;
  } ahbRespT;

  // Regions known to the decoder
  typedef enum logic [1:0] {regionNone, regionRam, regionGpio, regionClint} regionT;

endpackage

`default_nettype wire

// ==== verilog/uncore_consts.svh ====
// Uncore constants
// Bus widths, address map of the three regions and peripheral register offsets
`ifndef UNCORE_CONSTS_SVH
`define UNCORE_CONSTS_SVH

// Bus widths
`define XLEN 32
`define PA_BITS 32
`define PADDR_BITS 16

// Address map
`define RAM_BASE 32'h8000_0000
`define RAM_WORDS 1024
`define GPIO_BASE 32'h1006_0000
`define CLINT_BASE 32'h0200_0000
`define PERIPH_SIZE 32'h0001_0000

// GPIO register offsets
`define GPIO_OUT 16'h0000
`define GPIO_EN 16'h0004
`define GPIO_IN 16'h0008

// Timer register offsets
`define CLINT_MSIP 16'h0000
`define CLINT_CMP_LO 16'h4000
`define CLINT_CMP_HI 16'h4004
`define CLINT_TIME_LO 16'hBFF8
`define CLINT_TIME_HI 16'hBFFC

`endif
